// ==== Bender.yml ====
package:
  name: qu_core

sources:
  - files:
      - hdl/qu_pkg.sv
      - hdl/qu_fetch.sv
      - hdl/qu_fifo.sv
      - hdl/qu_decode.sv
      - hdl/qu_startup_ctrl.sv
      - hdl/qu_core.sv
  - target: simulation
    files:
      - sim/qu_core_tb.sv

// ==== hdl/qu_core.sv ====
`timescale 1ns/10ps

module qu_core
    import qu_pkg::*;
(
    input logic clk,
    input logic reset,
    input redirect_t redirect,
    input logic stall,
    input logic if_stall,
    input logic id_stall,
    output issue_t issue
);

    fetch_word_t fetch_word;
    fetch_word_t fifo_head;
    logic fetch_stall;
    logic fifo_wr_en;
    logic fifo_flush;
    logic fifo_empty;
    logic fifo_full;
    logic pop_en;
    logic id_en;

    assign fetch_stall = stall || if_stall || fifo_full;
    assign fifo_wr_en = fetch_word.valid && !fetch_stall; // A held word is written once
    assign fifo_flush = redirect.branch || redirect.jump || redirect.exception;
    assign pop_en = !stall && !id_stall && !fifo_empty && id_en;

    qu_fetch u_fetch (
        .clk(clk),
        .reset(reset),
        .stall(fetch_stall),
        .redirect(redirect),
        .word(fetch_word)
    );

    qu_fifo u_fifo (
        .clk(clk),
        .reset(reset),
        .flush(fifo_flush),
        .wr_en(fifo_wr_en),
        .wr_data(fetch_word),
        .rd_en(pop_en),
        .rd_data(fifo_head),
        .empty(fifo_empty),
        .full(fifo_full)
    );

    qu_decode u_decode (
        .en(pop_en), // Issue is valid exactly when the head is popped
        .word(fifo_head),
        .issue(issue)
    );

    qu_startup_ctrl u_startup_ctrl (
        .clk(clk),
        .reset(reset),
        .id_en(id_en)
    );

endmodule

// ==== hdl/qu_decode.sv ====
`timescale 1ns/10ps

module qu_decode
    import qu_pkg::*;
(
    input logic en,
    input fetch_word_t word,
    output issue_t issue
);

    logic nop;
    logic invalid;

    assign nop = (word.instr == '0);

    always_comb begin
        case (word.instr.rtype.opcode)
            OP_NOP: begin
                invalid = 1'b0;
            end
            OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                invalid = (word.instr.rtype.funct != '0); // No function variants defined yet
            end
            OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_JAL: begin
                invalid = 1'b0;
            end
            default: begin
                invalid = 1'b1;
            end
        endcase
    end

    always_comb begin
        issue.valid = en;
        issue.nop = nop;
        issue.invalid = invalid;
        issue.pc = word.pc;
        if (invalid) begin
            issue.instr = '0; // Later stages see a bubble
        end else begin
            issue.instr = word.instr;
        end
    end

endmodule

// ==== hdl/qu_fetch.sv ====
`timescale 1ns/10ps

module qu_fetch
    import qu_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    input redirect_t redirect,
    output fetch_word_t word
);

    logic [QU_INSTR_WIDTH-1:0] pmem [0:QU_PMEM_DEPTH-1];

    logic [QU_PC_WIDTH-1:0] pc;
    logic [QU_PC_WIDTH-1:0] new_pc;
    logic redirect_any;
    logic word_valid;
    logic [QU_PC_WIDTH-1:0] word_pc;
    logic [QU_INSTR_WIDTH-1:0] word_instr;

    initial begin
        $readmemh(QU_PMEM_FILE, pmem); // Program image is fixed at build time
    end

    assign redirect_any = redirect.branch | redirect.jump | redirect.exception;

    always_comb begin
        if (redirect.exception) begin
            new_pc = QU_EXC_VECTOR; // Exception outranks a branch in the same cycle
        end else begin
            new_pc = redirect.target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= QU_PC_RESET_VAL;
            word_valid <= 1'b0;
        end else if (redirect_any) begin
            pc <= new_pc;
            word_valid <= 1'b0; // Word from the old path is dropped
        end else if (!stall) begin
            pc <= pc + 1'b1; // Wraps at the end of program memory
            word_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!redirect_any && !stall) begin
            word_pc <= pc;
            word_instr <= pmem[pc];
        end
    end

    always_comb begin
        word.valid = word_valid;
        word.pc = word_pc;
        word.instr = word_instr;
    end

endmodule

// ==== hdl/qu_fifo.sv ====
`timescale 1ns/10ps

module qu_fifo
    import qu_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic flush,
    input logic wr_en,
    input fetch_word_t wr_data,
    input logic rd_en,
    output fetch_word_t rd_data,
    output logic empty,
    output logic full
);

    fetch_word_t mem [0:QU_FIFO_DEPTH-1];

    logic [QU_FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [QU_FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [QU_FIFO_PTR_WIDTH:0] count;
    logic do_wr;
    logic do_rd;

    assign empty = (count == '0);
    assign full = (count == QU_FIFO_DEPTH);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two so the pointer wraps
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_comb begin
        rd_data = mem[rd_ptr]; // Head is visible before the pop
        rd_data.valid = !empty;
    end

endmodule

// ==== hdl/qu_pkg.sv ====
package qu_pkg;

    localparam int QU_INSTR_WIDTH = 32;
    localparam int QU_PC_WIDTH = 5;
    localparam int QU_PMEM_DEPTH = 2 ** QU_PC_WIDTH;
    localparam logic [QU_PC_WIDTH-1:0] QU_PC_RESET_VAL = 5'd0;
    localparam logic [QU_PC_WIDTH-1:0] QU_EXC_VECTOR = 5'd24;
    localparam int QU_FIFO_DEPTH = 4;
    localparam int QU_FIFO_PTR_WIDTH = $clog2(QU_FIFO_DEPTH);
    localparam int QU_STARTUP_CYCLES = 4;
    localparam int QU_STARTUP_CNT_WIDTH = $clog2(QU_STARTUP_CYCLES + 1);
    localparam string QU_PMEM_FILE = "sim/program.mem";

    typedef enum logic [5:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_ADDI = 6'h08,
        OP_LW   = 6'h09,
        OP_SW   = 6'h0a,
        OP_BEQ  = 6'h0b,
        OP_JAL  = 6'h0c
    } opcode_e;

    typedef struct packed {
        opcode_e opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] shamt;
        logic [5:0] funct; // Must be zero for the register group
    } r_fmt_t;

    typedef struct packed {
        opcode_e opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t rtype;
        i_fmt_t itype;
    } instr_u;

    typedef struct packed {
        logic branch;
        logic jump;
        logic exception;
        logic [QU_PC_WIDTH-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic valid;
        logic [QU_PC_WIDTH-1:0] pc;
        instr_u instr;
    } fetch_word_t;

    typedef struct packed {
        logic valid;
        logic nop;
        logic invalid;
        logic [QU_PC_WIDTH-1:0] pc;
        instr_u instr;
    } issue_t;

endpackage

// ==== hdl/qu_startup_ctrl.sv ====
`timescale 1ns/10ps

module qu_startup_ctrl
    import qu_pkg::*;
(
    input logic clk,
    input logic reset,
    output logic id_en
);

    logic [QU_STARTUP_CNT_WIDTH-1:0] cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt != QU_STARTUP_CYCLES) begin
            cnt <= cnt + 1'b1; // Saturates at the startup count
        end
    end

    assign id_en = (cnt == QU_STARTUP_CYCLES);

endmodule

// ==== sim.f ====
hdl/qu_pkg.sv
hdl/qu_fetch.sv
hdl/qu_fifo.sv
hdl/qu_decode.sv
hdl/qu_startup_ctrl.sv
hdl/qu_core.sv
sim/qu_core_tb.sv

// ==== sim/program.mem ====
// One 32-bit instruction word per line in hex, word addresses 0 to 31
// Opcode in bits 31:26, funct in bits 5:0; zero words are nops
20200005
04221800
00000000
08811000
fc000123
0ca12000
10c51800
04221805
24e20010
28e20014
2c220008
33e0000a
00000000
14211000
20400003
00000001
08811000
0ca12000
80420007
20200005
04221800
00000000
24e20010
10c51800
20a00018
00000000
2c220008
fc000000
04221800
0cc12001
33e0000a
28e20014

// ==== sim/qu_core_tb.sv ====
`timescale 1ns/10ps

module qu_core_tb
    import qu_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int SEED = 45589;
    localparam int WAIT_LIMIT = 40; // Cycles allowed for one record or a full queue
    localparam int RUN_CYCLES = 8 + 20 + 30 + 210 + 25 + 25 + 40;

    logic clk;
    logic reset;
    redirect_t redirect;
    logic stall;
    logic if_stall;
    logic id_stall;
    issue_t issue;

    logic [QU_INSTR_WIDTH-1:0] model_mem [0:QU_PMEM_DEPTH-1];
    issue_t issued [$];
    logic [QU_PC_WIDTH-1:0] exp_pc;
    int err_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    qu_core u_core (
        .clk(clk),
        .reset(reset),
        .redirect(redirect),
        .stall(stall),
        .if_stall(if_stall),
        .id_stall(id_stall),
        .issue(issue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 3 / 2);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    always @(posedge clk) begin
        if (!reset && issue.valid) begin
            issued.push_back(issue); // Sampled before the edge updates the DUT
        end
    end

    function automatic issue_t expect_issue(input logic [QU_PC_WIDTH-1:0] pc);
        instr_u w;
        issue_t e;
        logic [5:0] op;
        w = model_mem[pc];
        op = w.rtype.opcode;
        e.valid = 1'b1;
        e.pc = pc;
        e.nop = (w == '0);
        if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR}) begin
            e.invalid = (w.rtype.funct != '0);
        end else begin
            e.invalid = !(op inside {OP_NOP, OP_ADDI, OP_LW, OP_SW, OP_BEQ, OP_JAL});
        end
        e.instr = e.invalid ? '0 : w;
        return e;
    endfunction

    task automatic compare_issue(input string name, input issue_t exp, input issue_t got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic compare_pc(input string name, input logic [QU_PC_WIDTH-1:0] exp,
                              input logic [QU_PC_WIDTH-1:0] got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Error at %0d ns: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic wait_records(input int n, output bit ok);
        int waited;
        waited = 0;
        while (issued.size() < n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        ok = (issued.size() >= n);
        if (!ok) begin
            err_count++;
            $display("No issued record arrived within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic wait_full();
        int waited;
        waited = 0;
        while (!u_core.fifo_full && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!u_core.fifo_full) begin
            err_count++;
            $display("The instruction queue never filled while id_stall was held");
        end
    endtask

    // Pops n records and checks that they follow exp_pc one by one
    task automatic check_next(input int n);
        issue_t rec;
        bit ok;
        for (int i = 0; i < n; i++) begin
            wait_records(1, ok);
            if (!ok) return;
            rec = issued.pop_front();
            compare_issue($sformatf("issue (pc %0d)", exp_pc), expect_issue(exp_pc), rec);
            exp_pc = exp_pc + 1'b1;
        end
    endtask

    task automatic check_target(input logic [QU_PC_WIDTH-1:0] first_pc, input int n);
        bit ok;
        wait_records(1, ok);
        if (ok) compare_pc("issue.pc", first_pc, issued[0].pc);
        exp_pc = first_pc;
        check_next(n);
    endtask

    // Records up to and including the redirect edge belong to the old path
    task automatic pulse_redirect(input redirect_t r);
        @(negedge clk);
        redirect = r;
        @(negedge clk);
        redirect = '0;
        check_next(issued.size());
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests_run++;
        if (err_count != start_err) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - start_err);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic test_startup();
        int start_err;
        int low_cycles;
        start_err = err_count;
        low_cycles = 0;
        while (!issue.valid && low_cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (!issue.valid) low_cycles++;
        end
        if (low_cycles < QU_STARTUP_CYCLES) begin
            err_count++;
            $display("Error at %0d ns: issue.valid low cycles expected >= %0d got %0d",
                     $time, QU_STARTUP_CYCLES, low_cycles);
        end
        check_target(QU_PC_RESET_VAL, 1);
        finish_test("test_startup", start_err);
    endtask

    task automatic test_sequence();
        int start_err;
        start_err = err_count;
        check_next(20);
        finish_test("test_sequence", start_err);
    endtask

    task automatic test_backpressure();
        int start_err;
        start_err = err_count;
        repeat (200) begin
            @(negedge clk);
            stall = ($urandom % 4) == 0;
            if_stall = ($urandom % 3) == 0;
            id_stall = ($urandom % 3) == 0;
        end
        @(negedge clk);
        stall = 1'b0;
        if_stall = 1'b0;
        id_stall = 1'b0;
        if (issued.size() == 0) begin
            err_count++;
            $display("Nothing was issued during the random stall run");
        end
        check_next(issued.size());
        finish_test("test_backpressure", start_err);
    endtask

    task automatic test_branch();
        int start_err;
        redirect_t r;
        start_err = err_count;
        r = '{branch: 1'b1, jump: 1'b0, exception: 1'b0, target: 5'd10};
        pulse_redirect(r);
        check_target(5'd10, 8);
        finish_test("test_branch", start_err);
    endtask

    task automatic test_exception();
        int start_err;
        redirect_t r;
        start_err = err_count;
        r = '{branch: 1'b0, jump: 1'b0, exception: 1'b1, target: 5'd3};
        pulse_redirect(r);
        check_target(QU_EXC_VECTOR, 6);
        finish_test("test_exception", start_err);
    endtask

    task automatic test_redirect_full();
        int start_err;
        redirect_t r;
        start_err = err_count;
        r = '{branch: 1'b0, jump: 1'b1, exception: 1'b0, target: 5'd17};
        @(negedge clk);
        id_stall = 1'b1;
        wait_full();
        pulse_redirect(r);
        wait_full(); // Queue refills from the jump target
        if (issued.size() != 0) begin
            err_count++;
            $display("A record was issued while id_stall was held");
        end
        @(negedge clk);
        id_stall = 1'b0;
        check_target(5'd17, 5);
        finish_test("test_redirect_full", start_err);
    endtask

    initial begin
        void'($urandom(SEED));
        $readmemh("sim/program.mem", model_mem);
        reset = 1'b1;
        redirect = '0;
        stall = 1'b0;
        if_stall = 1'b0;
        id_stall = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_startup();
        test_sequence();
        test_backpressure();
        test_branch();
        test_exception();
        test_redirect_full();
        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
